//--- fetch_predict.f
hdl/fetch_pkg.sv
hdl/pred_lookup_if.sv
hdl/resolve_if.sv
hdl/btb.sv
hdl/direction_predictor.sv
hdl/fetch_pc_gen.sv
hdl/fetch_predict_top.sv
verification/fetch_predict_tb.sv

//--- hdl/btb.sv
// branch target buffer, direct mapped and tagged
// two combinational read ports for the fetch pair, one write port from resolve
`timescale 1ns/1ps
`default_nettype none

module btb import fetch_pkg::*; (
	input logic clock,
	input logic reset,
	pred_lookup_if.tbl lookup,
	resolve_if.sink resolve
);

	btb_entry_t entries [btb_entries]; // the table itself

	pc_fields_t rd0, rd1; // slot 0 and slot 1 addresses, split
	pc_fields_t wr; // resolve address, split
	btb_entry_t entry0, entry1; // raw lines read out
	btb_entry_t new_entry; // line written on a taken resolve
	logic write_en;

	assign rd0.raw = lookup.pc0;
	assign rd1.raw = lookup.pc1;
	assign wr.raw = resolve.pc;

	// read port 0
	assign entry0 = entries[rd0.f.index];
	assign lookup.hit0 = lookup.entry_hit(entry0, rd0.f.tag);
	assign lookup.target0 = entry0.target;
	assign lookup.uncond0 = entry0.uncond;

	// read port 1, usually the neighbour index
	assign entry1 = entries[rd1.f.index];
	assign lookup.hit1 = lookup.entry_hit(entry1, rd1.f.tag);
	assign lookup.target1 = entry1.target;
	assign lookup.uncond1 = entry1.uncond;

	// only taken branches earn a line
	assign write_en = resolve.valid && resolve.taken;

	always_comb begin
		new_entry.valid = 1'b1;
		new_entry.uncond = resolve.uncond;
		new_entry.tag = wr.f.tag; // full tag, no aliasing
		new_entry.target = {resolve.target[pc_width-1:2], 2'b00}; // odd targets forced to a word
	end

	// valid bits are the only state cleared on reset
	// a taken resolve allocates, or overwrites whatever sits at that index
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < btb_entries; i++) begin
				entries[i].valid <= 1'b0;
			end
		end else if (write_en) begin
			entries[wr.f.index] <= new_entry; // visible to lookups next cycle
		end
	end

endmodule

`default_nettype wire

//--- hdl/direction_predictor.sv
// bimodal direction predictor
// 256 two-bit saturating counters, high bit is the taken guess
`timescale 1ns/1ps
`default_nettype none

module direction_predictor import fetch_pkg::*; (
	input logic clock,
	input logic reset,
	input logic [pc_width-1:0] pc0,
	resolve_if.sink resolve,
	output logic taken0,
	output logic taken1
);

	logic [1:0] pht [pht_entries]; // counter table

	logic [pc_width-1:0] pc1; // second slot of the pair
	logic [pht_index_bits-1:0] idx0, idx1, train_idx;
	logic [1:0] train_ctr; // counter being trained
	logic train_en;

	assign pc1 = pc0 + pc_width'(4);

	// pc bits 9:2, low bits ignored
	assign idx0 = pc0[pht_index_bits+1:2];
	assign idx1 = pc1[pht_index_bits+1:2];
	assign train_idx = resolve.pc[pht_index_bits+1:2];

	assign taken0 = pht[idx0][1]; // msb set means taken
	assign taken1 = pht[idx1][1];

	assign train_ctr = pht[train_idx];
	assign train_en = resolve.valid && !resolve.uncond; // jumps leave counters alone

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < pht_entries; i++) begin
				pht[i] <= ctr_weak_not_taken; // everything starts weakly not taken
			end
		end else if (train_en) begin
			if (resolve.taken) begin
				if (train_ctr != 2'b11) begin
					pht[train_idx] <= train_ctr + 2'd1; // step toward strong taken
				end
			end else begin
				if (train_ctr != 2'b00) begin
					pht[train_idx] <= train_ctr - 2'd1; // step toward strong not taken
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/fetch_pc_gen.sv
// fetch pc register and next pc select
// redirect beats predicted target, which beats the sequential pair
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen import fetch_pkg::*; (
	input logic clock,
	input logic reset,
	input logic advance, // fetch stage takes the current pair
	pred_lookup_if.requester lookup,
	input logic taken0,
	input logic taken1,
	resolve_if.sink resolve,
	output logic [pc_width-1:0] fetch_pc0
);

	logic redirect; // mispredict strobe this cycle
	logic pick0, pick1; // slot predicted to leave the straight line
	logic [pc_width-1:0] redirect_pc;
	logic [pc_width-1:0] predict_pc;
	logic [pc_width-1:0] seq_pc;
	pc_fields_t load_pc; // value for the pc register

	// both slot addresses go out to the btb
	assign lookup.pc0 = fetch_pc0;
	assign lookup.pc1 = fetch_pc0 + pc_width'(4);

	assign redirect = resolve.valid && resolve.mispredict;
	// taken goes to the real target, not taken falls through
	assign redirect_pc = resolve.taken ? resolve.target : resolve.pc + pc_width'(4);

	// a hit only redirects when a jump or predicted taken
	assign pick0 = lookup.hit0 && (lookup.uncond0 || taken0);
	assign pick1 = lookup.hit1 && (lookup.uncond1 || taken1);

	assign seq_pc = fetch_pc0 + pc_width'(8); // next pair

	always_comb begin
		if (pick0) begin
			predict_pc = lookup.target0; // slot 0 is older, wins
		end else if (pick1) begin
			predict_pc = lookup.target1;
		end else begin
			predict_pc = seq_pc;
		end
	end

	always_comb begin
		load_pc.raw = fetch_pc0; // hold by default
		if (redirect) begin
			load_pc.raw = redirect_pc; // back end knows better
		end else if (advance) begin
			load_pc.raw = predict_pc;
		end
		load_pc.f.offset = 2'b00; // word align whatever is loaded
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			fetch_pc0 <= reset_pc;
		end else begin
			fetch_pc0 <= load_pc.raw;
		end
	end

endmodule

`default_nettype wire

//--- hdl/fetch_pkg.sv
// fetch prediction package
// table geometry, reset pc, pc field view and btb entry layout
`default_nettype none

package fetch_pkg;

	localparam int pc_width = 64; // full address width
	localparam int btb_index_bits = 6; // 64 btb entries
	localparam int btb_entries = 1 << btb_index_bits;
	localparam int btb_tag_bits = pc_width - btb_index_bits - 2; // 56 bits above index
	localparam int pht_index_bits = 8; // 256 counters
	localparam int pht_entries = 1 << pht_index_bits;

	localparam logic [pc_width-1:0] reset_pc = '0; // first fetch address
	localparam logic [1:0] ctr_weak_not_taken = 2'b01; // counter reset state

	// one pc word, seen either as a raw address or split for btb indexing
	typedef union packed {
		logic [pc_width-1:0] raw;
		struct packed {
			logic [btb_tag_bits-1:0] tag;
			logic [btb_index_bits-1:0] index;
			logic [1:0] offset; // byte offset, ignored
		} f;
	} pc_fields_t;

	// btb line, 122 bits
	typedef struct packed {
		logic valid;
		logic uncond; // jump, always taken
		logic [btb_tag_bits-1:0] tag;
		logic [pc_width-1:0] target; // word aligned
	} btb_entry_t;

endpackage

`default_nettype wire

//--- hdl/fetch_predict_top.sv
// fetch prediction front end
// btb, bimodal predictor and pc generator behind plain ports
`timescale 1ns/1ps
`default_nettype none

module fetch_predict_top import fetch_pkg::*; (
	input logic clock,
	input logic reset,
	input logic advance,
	input logic resolve_valid,
	input logic resolve_taken,
	input logic resolve_uncond,
	input logic resolve_mispredict,
	input logic [pc_width-1:0] resolve_pc,
	input logic [pc_width-1:0] resolve_target,
	output logic [pc_width-1:0] fetch_pc0,
	output logic [pc_width-1:0] fetch_pc1
);

	pred_lookup_if lookup ();
	resolve_if resolve ();

	logic taken0, taken1; // direction guesses per slot

	// resolve bus from the plain ports
	assign resolve.valid = resolve_valid;
	assign resolve.pc = resolve_pc;
	assign resolve.target = resolve_target;
	assign resolve.taken = resolve_taken;
	assign resolve.uncond = resolve_uncond;
	assign resolve.mispredict = resolve_mispredict;

	assign fetch_pc1 = lookup.pc1; // slot 1, pc0 plus 4

	btb btb (
		.clock (clock),
		.reset (reset),
		.lookup (lookup.tbl),
		.resolve (resolve.sink)
	);

	direction_predictor direction_predictor (
		.clock (clock),
		.reset (reset),
		.pc0 (fetch_pc0),
		.resolve (resolve.sink),
		.taken0 (taken0),
		.taken1 (taken1)
	);

	fetch_pc_gen fetch_pc_gen (
		.clock (clock),
		.reset (reset),
		.advance (advance),
		.lookup (lookup.requester),
		.taken0 (taken0),
		.taken1 (taken1),
		.resolve (resolve.sink),
		.fetch_pc0 (fetch_pc0)
	);

endmodule

`default_nettype wire

//--- hdl/pred_lookup_if.sv
// btb lookup bus between the pc generator and the target buffer
`timescale 1ns/1ps
`default_nettype none

interface pred_lookup_if import fetch_pkg::*; ();
	logic [pc_width-1:0] pc0, pc1; // slot addresses
	logic hit0, hit1;
	logic [pc_width-1:0] target0, target1;
	logic uncond0, uncond1;

	// valid entry with matching tag
	function automatic logic entry_hit(input btb_entry_t entry,
		input logic [btb_tag_bits-1:0] tag);
		return entry.valid && (entry.tag == tag);
	endfunction

	modport requester (output pc0, pc1, input hit0, hit1, target0, target1, uncond0, uncond1);
	modport tbl (input pc0, pc1, output hit0, hit1, target0, target1, uncond0, uncond1,
		import entry_hit);
endinterface

`default_nettype wire

//--- hdl/resolve_if.sv
// resolved branch report from the back end
// one strobe per cycle, trains both tables and carries the redirect
`timescale 1ns/1ps
`default_nettype none

interface resolve_if import fetch_pkg::*; ();
	logic valid; // single cycle strobe
	logic [pc_width-1:0] pc; // branch address
	logic [pc_width-1:0] target; // actual target when taken
	logic taken;
	logic uncond; // jump, no counter training
	logic mispredict; // front end went the wrong way

	// back end side
	modport source (output valid, pc, target, taken, uncond, mispredict);

	// table and pc generator side
	modport sink (input valid, pc, target, taken, uncond, mispredict);

endinterface

`default_nettype wire

//--- verification/fetch_predict_tb.sv
// testbench for the fetch prediction front end
// reference btb and counter tables predict every fetch pc, checked each cycle
`timescale 1ns/1ps
`default_nettype none

module fetch_predict_tb;

	localparam logic [1:0] ctr_reset = 2'b01; // weakly not taken

	logic clock, reset, advance;
	logic resolve_valid, resolve_taken, resolve_uncond, resolve_mispredict;
	logic [63:0] resolve_pc, resolve_target, fetch_pc0, fetch_pc1;

	// reference model state
	logic m_valid [64];
	logic m_uncond [64];
	logic [55:0] m_tag [64];
	logic [63:0] m_target [64];
	logic [1:0] m_ctr [256];
	logic [63:0] exp_pc0, next_pc;

	logic [31:0] rng = 32'hcbb9f436;
	int errors = 0, checks = 0, tests = 0, test_errors_start = 0;
	string test_name;
	logic [63:0] a, b, t, t2;

	fetch_predict_top UUT (.clock, .reset, .advance, .resolve_valid, .resolve_taken,
		.resolve_uncond, .resolve_mispredict, .resolve_pc, .resolve_target,
		.fetch_pc0, .fetch_pc1);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		#200us;
		$display("watchdog expired, simulation stuck");
		$display("Done: errors found");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// model slot decision, hit plus jump or counter msb
	function automatic logic model_redirects(input logic [63:0] pc);
		logic [5:0] i;
		i = pc[7:2];
		return m_valid[i] && (m_tag[i] == pc[63:8]) && (m_uncond[i] || m_ctr[pc[9:2]][1]);
	endfunction

	always @(posedge clock) begin
		if (reset) begin
			exp_pc0 = 64'h0;
			for (int i = 0; i < 64; i++) m_valid[i] = 1'b0;
			for (int i = 0; i < 256; i++) m_ctr[i] = ctr_reset;
		end else begin
			next_pc = exp_pc0; // hold
			if (resolve_valid && resolve_mispredict) begin
				next_pc = resolve_taken ? resolve_target : resolve_pc + 64'd4;
			end else if (advance) begin
				if (model_redirects(exp_pc0)) next_pc = m_target[exp_pc0[7:2]];
				else if (model_redirects(exp_pc0 + 64'd4)) next_pc = m_target[exp_pc0[7:2] + 6'd1];
				else next_pc = exp_pc0 + 64'd8;
			end
			next_pc[1:0] = 2'b00;
			// tables train after the lookup above
			if (resolve_valid && resolve_taken) begin
				m_valid[resolve_pc[7:2]] = 1'b1;
				m_uncond[resolve_pc[7:2]] = resolve_uncond;
				m_tag[resolve_pc[7:2]] = resolve_pc[63:8];
				m_target[resolve_pc[7:2]] = {resolve_target[63:2], 2'b00};
			end
			if (resolve_valid && !resolve_uncond) begin
				if (resolve_taken && m_ctr[resolve_pc[9:2]] != 2'b11) m_ctr[resolve_pc[9:2]]++;
				else if (!resolve_taken && m_ctr[resolve_pc[9:2]] != 2'b00) m_ctr[resolve_pc[9:2]]--;
			end
			exp_pc0 = next_pc;
		end
	end

	// mid cycle, outputs settled
	always @(negedge clock) begin
		if (!reset) begin
			checks += 2;
			assert (fetch_pc0 === exp_pc0) else begin
				errors++;
				$display("[ERROR] fetch_pc0: got %h expected %h", fetch_pc0, exp_pc0);
			end
			assert (fetch_pc1 === exp_pc0 + 64'd4) else begin
				errors++;
				$display("[ERROR] fetch_pc1: got %h expected %h", fetch_pc1, exp_pc0 + 64'd4);
			end
		end
	end

	task automatic clear_inputs();
		{advance, resolve_valid, resolve_taken, resolve_uncond, resolve_mispredict} = '0;
		resolve_pc = '0;
		resolve_target = '0;
	endtask

	task automatic random_addr(output logic [63:0] addr);
		rng = xorshift32(rng);
		addr[63:32] = rng;
		rng = xorshift32(rng);
		addr[31:0] = {rng[31:2], 2'b00}; // word aligned
	endtask

	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %s: got %h expected %h", name, got, exp);
		end
	endtask

	// one strobe, held for exactly one edge
	task automatic resolve_branch(input logic [63:0] pc, input logic [63:0] target,
		input logic taken, input logic uncond, input logic mispredict, input logic adv);
		resolve_valid = 1'b1;
		resolve_taken = taken;
		resolve_uncond = uncond;
		resolve_mispredict = mispredict;
		resolve_pc = pc;
		resolve_target = target;
		advance = adv;
		@(posedge clock) #1;
		clear_inputs();
	endtask

	task automatic advance_once();
		advance = 1'b1;
		@(posedge clock) #1;
		advance = 1'b0;
	endtask

	task automatic wait_for_pc(input logic [63:0] exp);
		logic found;
		found = 1'b0;
		for (int n = 0; n < 20 && !found; n++) begin
			if (fetch_pc0 === exp) found = 1'b1;
			else @(posedge clock) #1;
		end
		if (!found) begin
			errors++;
			$display("timeout, fetch_pc0 never reached %h", exp);
		end
	endtask

	// not taken mispredict just before addr lands the pc there
	task automatic jump_to(input logic [63:0] addr);
		resolve_branch(addr - 64'd4, 64'h0, 1'b0, 1'b0, 1'b1, 1'b0);
		wait_for_pc(addr);
	endtask

	task automatic fetch_from(input logic [63:0] start, input logic [63:0] exp);
		jump_to(start);
		advance_once();
		wait_for_pc(exp);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors_start = errors;
		tests++;
	endtask

	task automatic finish_test();
		$display("test %s: %s", test_name, (errors == test_errors_start) ? "ok" : "failed");
	endtask

	initial begin
		clear_inputs();
		reset = 1'b1;
		repeat (10) @(posedge clock);
		#1 reset = 1'b0;

		start_test("reset_and_sequential");
		check_eq("fetch_pc0", fetch_pc0, 64'h0);
		check_eq("fetch_pc1", fetch_pc1, 64'h4);
		repeat (3) advance_once();
		repeat (2) @(posedge clock) #1; // hold cycles
		check_eq("fetch_pc0", fetch_pc0, 64'd24);
		finish_test();

		start_test("mispredict_redirect");
		random_addr(a);
		random_addr(t);
		resolve_branch(a, t | 64'h3, 1'b1, 1'b1, 1'b1, 1'b1); // odd target, advance too
		wait_for_pc(t);
		random_addr(b);
		resolve_branch(b, 64'h0, 1'b0, 1'b0, 1'b1, 1'b1);
		wait_for_pc(b + 64'd4);
		finish_test();

		start_test("unconditional_allocation");
		random_addr(a);
		random_addr(t);
		random_addr(t2);
		resolve_branch(a, t, 1'b1, 1'b1, 1'b0, 1'b0);
		fetch_from(a, t); // slot 0
		fetch_from(a - 64'd4, t); // slot 1
		resolve_branch(a + 64'd4, t2, 1'b1, 1'b1, 1'b0, 1'b0);
		fetch_from(a, t); // both hit, slot 0 first
		finish_test();

		start_test("counter_training");
		random_addr(a);
		random_addr(t);
		resolve_branch(a, t, 1'b1, 1'b0, 1'b0, 1'b0); // allocate, ctr 10
		resolve_branch(a, t, 1'b0, 1'b0, 1'b0, 1'b0); // back to 01
		fetch_from(a, a + 64'd8);
		resolve_branch(a, t, 1'b1, 1'b0, 1'b0, 1'b0);
		fetch_from(a, t);
		repeat (2) resolve_branch(a, t, 1'b0, 1'b0, 1'b0, 1'b0); // down to 00
		fetch_from(a, a + 64'd8);
		repeat (5) resolve_branch(a, t, 1'b1, 1'b0, 1'b0, 1'b0); // sticks at 11
		resolve_branch(a, t, 1'b0, 1'b0, 1'b0, 1'b0); // 10, a wrap would give 00
		fetch_from(a, t);
		finish_test();

		start_test("tag_mismatch_replacement");
		random_addr(a);
		random_addr(t);
		random_addr(t2);
		b = a ^ (64'h1 << 40); // same index, other tag
		resolve_branch(a, t, 1'b1, 1'b1, 1'b0, 1'b0);
		fetch_from(b, b + 64'd8);
		resolve_branch(b, t2, 1'b1, 1'b1, 1'b0, 1'b0);
		fetch_from(a, a + 64'd8);
		fetch_from(b, t2);
		finish_test();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
